// File: Makefile
TOP := tb_dec

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// File: dec_pkg.sv
package dec_pkg;

    localparam int XLEN       = 32;
    localparam int REG_IDX_W  = 5;
    localparam int ROB_ID_W   = 4;
    localparam int CALC_OP_W  = 4;
    localparam int MEM_TYPE_W = 4;
    localparam int OPCODE_W   = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [ROB_ID_W-1:0]   rob_id_t;
    typedef logic [CALC_OP_W-1:0]  calc_op_t;
    typedef logic [MEM_TYPE_W-1:0] mem_type_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;

    localparam rob_id_t NO_DEP = '1;  // Operand needs no ROB entry

    localparam calc_op_t CALC_ADD_SUB = 4'b0000;
    localparam calc_op_t CALC_SLL     = 4'b0001;
    localparam calc_op_t CALC_SLT     = 4'b0010;
    localparam calc_op_t CALC_SLTU    = 4'b0011;
    localparam calc_op_t CALC_XOR     = 4'b0100;
    localparam calc_op_t CALC_SRL_SRA = 4'b0101;
    localparam calc_op_t CALC_OR      = 4'b0110;
    localparam calc_op_t CALC_AND     = 4'b0111;
    localparam calc_op_t CALC_SEQ     = 4'b1000;
    localparam calc_op_t CALC_SNE     = 4'b1001;
    localparam calc_op_t CALC_SGE     = 4'b1101;
    localparam calc_op_t CALC_SGEU    = 4'b1111;

    localparam mem_type_t MEM_LB  = 4'b0000;
    localparam mem_type_t MEM_LH  = 4'b0001;
    localparam mem_type_t MEM_LW  = 4'b0010;
    localparam mem_type_t MEM_LBU = 4'b0100;
    localparam mem_type_t MEM_LHU = 4'b0101;
    localparam mem_type_t MEM_SB  = 4'b1000;
    localparam mem_type_t MEM_SH  = 4'b1001;
    localparam mem_type_t MEM_SW  = 4'b1010;

    // Major opcodes, instr[6:2]
    localparam opcode_t OP_LUI    = 5'b01101;
    localparam opcode_t OP_AUIPC  = 5'b00101;
    localparam opcode_t OP_JAL    = 5'b11011;
    localparam opcode_t OP_JALR   = 5'b11001;
    localparam opcode_t OP_BRANCH = 5'b11000;
    localparam opcode_t OP_LOAD   = 5'b00000;
    localparam opcode_t OP_STORE  = 5'b01000;
    localparam opcode_t OP_IMM    = 5'b00100;
    localparam opcode_t OP_REG    = 5'b01100;

    typedef enum logic [2:0] {
        STORE_BYTE = 3'd0,
        STORE_HALF = 3'd1,
        STORE_WORD = 3'd2,
        REG        = 3'd3,
        JALR       = 3'd4,
        BRANCH     = 3'd5
    } rob_type_e;

    typedef enum logic [1:0] {
        COMMIT       = 2'd0,
        EXECUTE      = 2'd1,
        WRITE_RESULT = 2'd2
    } rob_state_e;

    typedef enum logic [2:0] {
        CLS_NONE   = 3'd0,
        CLS_UPPER  = 3'd1,  // LUI, AUIPC
        CLS_JAL    = 3'd2,
        CLS_JALR   = 3'd3,
        CLS_BRANCH = 3'd4,
        CLS_LOAD   = 3'd5,
        CLS_STORE  = 3'd6,
        CLS_ALU    = 3'd7   // OP and OP-IMM
    } instr_class_e;

    typedef struct packed {
        xlen_t instr;
        xlen_t addr;
        xlen_t age;
        logic  pred_jump;
        xlen_t jump_addr;
    } fetch_pkt_t;

    typedef struct packed {
        instr_class_e cls;
        reg_idx_t     rd;
        reg_idx_t     rs1;
        reg_idx_t     rs2;
        xlen_t        imm;
        calc_op_t     calc_op;
        logic         calc_alt;  // SUB / SRA select
        mem_type_t    mem_type;
        rob_type_e    rob_type;
        logic         use_rs2;   // Second operand from rs2, not imm
        xlen_t        result;    // Upper and JAL only
    } decoded_instr_t;

    typedef struct packed {
        rob_id_t dep;
        xlen_t   value;
    } operand_t;

    typedef struct packed {
        logic  found;
        xlen_t value;
    } rob_hit_t;

    typedef struct packed {
        rob_type_e  rob_type;
        rob_state_e rob_state;
        reg_idx_t   dest;
        xlen_t      result_value;
        xlen_t      instr_addr;
        xlen_t      jump_addr;
        logic       is_jump;
        calc_op_t   calc_op;
        logic       calc_alt;
        rob_id_t    dep1;
        rob_id_t    dep2;
        xlen_t      value1;
        xlen_t      value2;
        xlen_t      imm;
        rob_id_t    rob_id;
        mem_type_t  mem_type;
        xlen_t      age;
    } dispatch_entry_t;

    typedef struct packed {
        logic rob;
        logic rs;
        logic lb;
        logic sb;
    } unit_full_t;

    typedef struct packed {
        logic rob;
        logic rs;
        logic lsb;
        logic rf;
    } unit_ready_t;

endpackage

// File: dec_top.sv
`timescale 1ns/1ps

module dec_top (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     fetch_valid,
    input  logic                     flush,
    input  dec_pkg::fetch_pkt_t      fetch,
    output dec_pkg::reg_idx_t        rs1,
    output dec_pkg::reg_idx_t        rs2,
    input  dec_pkg::operand_t        rf_src1,
    input  dec_pkg::operand_t        rf_src2,
    input  dec_pkg::rob_hit_t        rob_src1,
    input  dec_pkg::rob_hit_t        rob_src2,
    input  dec_pkg::rob_id_t         rob_next_id,
    input  dec_pkg::unit_full_t      full,
    output logic                     stall,
    output dec_pkg::unit_ready_t     ready,
    output dec_pkg::dispatch_entry_t entry
);
    import dec_pkg::*;

    decoded_instr_t dec;
    operand_t       src1;
    operand_t       src2;

    rv32i_field_decoder field_decoder_i (
        .instr (fetch.instr),
        .addr  (fetch.addr),
        .dec   (dec)
    );

    assign rs1 = dec.rs1;  // RF lookup addresses
    assign rs2 = dec.rs2;

    operand_resolver operand_resolver_i (
        .rf_src1  (rf_src1),
        .rf_src2  (rf_src2),
        .rob_src1 (rob_src1),
        .rob_src2 (rob_src2),
        .src1     (src1),
        .src2     (src2)
    );

    dispatch_unit dispatch_unit_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .fetch_valid (fetch_valid),
        .flush       (flush),
        .fetch       (fetch),
        .dec         (dec),
        .src1        (src1),
        .src2        (src2),
        .rob_next_id (rob_next_id),
        .full        (full),
        .stall       (stall),
        .ready       (ready),
        .entry       (entry)
    );

endmodule

// File: dispatch_unit.sv
`timescale 1ns/1ps

module dispatch_unit (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     fetch_valid,
    input  logic                     flush,
    input  dec_pkg::fetch_pkt_t      fetch,
    input  dec_pkg::decoded_instr_t  dec,
    input  dec_pkg::operand_t        src1,
    input  dec_pkg::operand_t        src2,
    input  dec_pkg::rob_id_t         rob_next_id,
    input  dec_pkg::unit_full_t      full,
    output logic                     stall,
    output dec_pkg::unit_ready_t     ready,
    output dec_pkg::dispatch_entry_t entry
);
    import dec_pkg::*;

    unit_ready_t     need;
    logic            lsb_full;
    logic            blocked;
    logic            active;
    dispatch_entry_t entry_next;

    always_comb begin
        need = '0;
        case (dec.cls)
            CLS_UPPER, CLS_JAL: begin
                need.rob = 1'b1;
                need.rf  = 1'b1;
            end
            CLS_JALR, CLS_ALU: begin
                need.rob = 1'b1;
                need.rs  = 1'b1;
                need.rf  = 1'b1;
            end
            CLS_BRANCH: begin
                need.rob = 1'b1;
                need.rs  = 1'b1;
            end
            CLS_LOAD: begin
                need.rob = 1'b1;
                need.lsb = 1'b1;
                need.rf  = 1'b1;
            end
            CLS_STORE: begin
                need.rob = 1'b1;
                need.lsb = 1'b1;
            end
            default: need = '0;
        endcase
    end

    assign lsb_full = (dec.cls == CLS_STORE) ? full.sb : full.lb;  // Split load/store buffers
    assign blocked  = (need.rob && full.rob) || (need.rs && full.rs) || (need.lsb && lsb_full);
    assign active   = fetch_valid && !flush && (|need);  // CLS_NONE needs nothing

    always_comb begin
        entry_next              = '0;
        entry_next.rob_type     = dec.rob_type;
        entry_next.dest         = dec.rd;
        entry_next.result_value = dec.result;
        entry_next.instr_addr   = fetch.addr;
        entry_next.jump_addr    = fetch.jump_addr;
        entry_next.calc_op      = dec.calc_op;
        entry_next.calc_alt     = dec.calc_alt;
        entry_next.dep1         = src1.dep;
        entry_next.value1       = src1.value;
        entry_next.imm          = dec.imm;
        entry_next.rob_id       = rob_next_id;
        entry_next.mem_type     = dec.mem_type;
        entry_next.age          = fetch.age;

        if (dec.cls == CLS_UPPER || dec.cls == CLS_JAL) begin
            entry_next.rob_state = WRITE_RESULT;  // Value known at dispatch
        end else begin
            entry_next.rob_state = EXECUTE;
        end

        case (dec.cls)
            CLS_JAL, CLS_JALR: entry_next.is_jump = 1'b1;
            CLS_BRANCH:        entry_next.is_jump = fetch.pred_jump;
            default:           entry_next.is_jump = 1'b0;
        endcase

        if (dec.use_rs2) begin
            entry_next.dep2   = src2.dep;
            entry_next.value2 = src2.value;
        end else begin
            entry_next.dep2   = NO_DEP;  // I-format immediate operand
            entry_next.value2 = dec.imm;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            stall <= 1'b0;
            ready <= '0;
        end else if (active) begin
            stall <= blocked;
            ready <= blocked ? unit_ready_t'('0) : need;
        end else begin
            stall <= 1'b0;
            ready <= '0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (active && !blocked) begin
            entry <= entry_next;
        end
    end

    stall_ready_excl_a: assert property (
        @(posedge clk_in) disable iff (rst_in) !(stall && (|ready))
    ) else $error("stall and ready high together");

    // A pulse always allocates a ROB slot and follows an accepted fetch
    ready_has_rob_a: assert property (
        @(posedge clk_in) disable iff (rst_in)
        (|ready) |-> (ready.rob && $past(fetch_valid && !flush))
    ) else $error("ready pulse without rob or without a valid fetch");

endmodule

// File: operand_resolver.sv
`timescale 1ns/1ps

module operand_resolver (
    input  dec_pkg::operand_t rf_src1,
    input  dec_pkg::operand_t rf_src2,
    input  dec_pkg::rob_hit_t rob_src1,
    input  dec_pkg::rob_hit_t rob_src2,
    output dec_pkg::operand_t src1,
    output dec_pkg::operand_t src2
);
    import dec_pkg::*;

    // RF value if committed, else ROB bypass, else wait on the tag
    function automatic operand_t resolve(input operand_t rf, input rob_hit_t rob);
        operand_t res;
        if (rf.dep == NO_DEP) begin
            res = rf;
        end else if (rob.found) begin
            res.dep   = NO_DEP;  // Result already written back
            res.value = rob.value;
        end else begin
            res.dep   = rf.dep;
            res.value = '0;
        end
        return res;
    endfunction

    assign src1 = resolve(rf_src1, rob_src1);
    assign src2 = resolve(rf_src2, rob_src2);

endmodule

// File: rv32i_field_decoder.sv
`timescale 1ns/1ps

module rv32i_field_decoder (
    input  dec_pkg::xlen_t          instr,
    input  dec_pkg::xlen_t          addr,
    output dec_pkg::decoded_instr_t dec
);
    import dec_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    logic       legal_major;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    xlen_t      imm_shamt;

    assign opcode    = instr[6:2];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    assign imm_i     = {{20{instr[31]}}, instr[31:20]};
    assign imm_s     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b     = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u     = {instr[31:12], 12'b0};
    assign imm_j     = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_shamt = {27'b0, instr[24:20]};

    always_comb begin
        dec          = '0;
        dec.cls      = CLS_NONE;
        dec.rd       = instr[11:7];
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        dec.calc_op  = CALC_ADD_SUB;
        dec.rob_type = REG;
        if (instr[1:0] == 2'b11) begin  // 32-bit encodings only
            case (opcode)
                OP_LUI: begin
                    dec.cls    = CLS_UPPER;
                    dec.imm    = imm_u;
                    dec.result = imm_u;
                end
                OP_AUIPC: begin
                    dec.cls    = CLS_UPPER;
                    dec.imm    = imm_u;
                    dec.result = addr + imm_u;
                end
                OP_JAL: begin
                    dec.cls    = CLS_JAL;
                    dec.imm    = imm_j;
                    dec.result = addr + 32'd4;  // Link value
                end
                OP_JALR: begin
                    dec.cls      = CLS_JALR;
                    dec.imm      = imm_i;
                    dec.rob_type = JALR;
                    dec.calc_op  = CALC_ADD_SUB;  // Target is rs1 + imm
                    dec.calc_alt = 1'b0;
                end
                OP_BRANCH: begin
                    dec.cls      = CLS_BRANCH;
                    dec.imm      = imm_b;
                    dec.rob_type = BRANCH;
                    dec.use_rs2  = 1'b1;
                    // BLT and BLTU reuse the existing compare codes
                    if (funct3 == 3'b100) begin
                        dec.calc_op = CALC_SLT;
                    end else if (funct3 == 3'b110) begin
                        dec.calc_op = CALC_SLTU;
                    end else begin
                        dec.calc_op = {1'b1, funct3};
                    end
                end
                OP_LOAD: begin
                    dec.cls      = CLS_LOAD;
                    dec.imm      = imm_i;
                    dec.mem_type = {1'b0, funct3};
                end
                OP_STORE: begin
                    dec.cls      = CLS_STORE;
                    dec.imm      = imm_s;
                    dec.mem_type = {1'b1, funct3};
                    dec.use_rs2  = 1'b1;
                    case (funct3[1:0])
                        2'b00:   dec.rob_type = STORE_BYTE;
                        2'b01:   dec.rob_type = STORE_HALF;
                        default: dec.rob_type = STORE_WORD;
                    endcase
                end
                OP_IMM: begin
                    dec.cls      = CLS_ALU;
                    dec.calc_op  = {1'b0, funct3};
                    dec.calc_alt = (funct3 == 3'b101) ? funct7_b5 : 1'b0;  // No SUBI
                    if (funct3 == 3'b001 || funct3 == 3'b101) begin
                        dec.imm = imm_shamt;
                    end else begin
                        dec.imm = imm_i;
                    end
                end
                OP_REG: begin
                    dec.cls      = CLS_ALU;
                    dec.calc_op  = {1'b0, funct3};
                    dec.calc_alt = funct7_b5;
                    dec.use_rs2  = 1'b1;
                end
                default: dec.cls = CLS_NONE;
            endcase
        end
    end

    assign legal_major = opcode inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
                                        OP_LOAD, OP_STORE, OP_IMM, OP_REG};

    always_comb begin
        assert final (instr[1:0] != 2'b11 || !legal_major || dec.cls != CLS_NONE)
            else $error("legal opcode %b classified as CLS_NONE", opcode);
    end

endmodule

// File: tb.f
+incdir+.
dec_pkg.sv
rv32i_field_decoder.sv
operand_resolver.sv
dispatch_unit.sv
dec_top.sv
tb_dec.sv

// File: tb_dec_model.svh
`ifndef TB_DEC_MODEL_SVH
`define TB_DEC_MODEL_SVH

logic [31:0] lfsr_state = 32'h7c74_2631;

// Galois LFSR, one step per random bit
function automatic xlen_t rand_bits(input int n);
    xlen_t r;
    int    i;
    r = '0;
    for (i = 0; i < n; i++) begin
        r          = {r[30:0], lfsr_state[0]};
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
endfunction

task automatic check_eq(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
        $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        $display("tests failed");
        $fatal(1, "value mismatch on %s", name);
    end
endtask

function automatic xlen_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

function automatic xlen_t enc_r(input logic [6:0] f7, input reg_idx_t rb, input reg_idx_t ra,
                                input logic [2:0] f3, input reg_idx_t rd);
    return {f7, rb, ra, f3, rd, OP_REG, 2'b11};
endfunction

function automatic xlen_t enc_i(input opcode_t op, input logic [11:0] imm, input reg_idx_t ra,
                                input logic [2:0] f3, input reg_idx_t rd);
    return {imm, ra, f3, rd, op, 2'b11};
endfunction

function automatic xlen_t enc_s(input logic [11:0] imm, input reg_idx_t rb, input reg_idx_t ra,
                                input logic [2:0] f3);
    return {imm[11:5], rb, ra, f3, imm[4:0], OP_STORE, 2'b11};
endfunction

// Bit 0 of the offset is not encoded
function automatic xlen_t enc_b(input logic [12:0] imm, input reg_idx_t rb, input reg_idx_t ra,
                                input logic [2:0] f3);
    return {imm[12], imm[10:5], rb, ra, f3, imm[4:1], imm[11], OP_BRANCH, 2'b11};
endfunction

function automatic xlen_t enc_u(input opcode_t op, input logic [19:0] imm, input reg_idx_t rd);
    return {imm, rd, op, 2'b11};
endfunction

function automatic xlen_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL, 2'b11};
endfunction

// Units as {rob, rs, lsb, rf}
function automatic unit_ready_t units_for(input opcode_t op);
    case (op)
        OP_LUI, OP_AUIPC, OP_JAL: return 4'b1001;
        OP_JALR, OP_IMM, OP_REG:  return 4'b1101;
        OP_BRANCH:                return 4'b1100;
        OP_LOAD:                  return 4'b1011;
        OP_STORE:                 return 4'b1010;
        default:                  return 4'b0000;
    endcase
endfunction

function automatic calc_op_t branch_op(input logic [2:0] f3);
    case (f3)
        3'd0:    return CALC_SEQ;
        3'd1:    return CALC_SNE;
        3'd4:    return CALC_SLT;
        3'd5:    return CALC_SGE;
        3'd6:    return CALC_SLTU;
        default: return CALC_SGEU;
    endcase
endfunction

function automatic rob_type_e store_rob_type(input logic [2:0] f3);
    case (f3)
        3'd0:    return STORE_BYTE;
        3'd1:    return STORE_HALF;
        default: return STORE_WORD;
    endcase
endfunction

`endif

// File: tb_dec.sv
`timescale 1ns/1ps

module tb_dec;
    import dec_pkg::*;

    localparam int CLK_NS      = 100;
    localparam int TEST_CYCLES = 70;  // Reset plus all directed tests
    localparam int WATCHDOG_NS = (TEST_CYCLES + 30) * CLK_NS;

    logic            clk_in;
    logic            rst_in;
    logic            fetch_valid;
    logic            flush;
    fetch_pkt_t      fetch;
    reg_idx_t        rs1;
    reg_idx_t        rs2;
    operand_t        rf_src1;
    operand_t        rf_src2;
    rob_hit_t        rob_src1;
    rob_hit_t        rob_src2;
    rob_id_t         rob_next_id;
    unit_full_t      full;
    logic            stall;
    unit_ready_t     ready;
    dispatch_entry_t entry;

    `include "tb_dec_model.svh"

    dec_top dec_top_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .fetch_valid (fetch_valid),
        .flush       (flush),
        .fetch       (fetch),
        .rs1         (rs1),
        .rs2         (rs2),
        .rf_src1     (rf_src1),
        .rf_src2     (rf_src2),
        .rob_src1    (rob_src1),
        .rob_src2    (rob_src2),
        .rob_next_id (rob_next_id),
        .full        (full),
        .stall       (stall),
        .ready       (ready),
        .entry       (entry)
    );

    always #(CLK_NS / 2) clk_in = ~clk_in;

    task automatic step();
        @(posedge clk_in);
        @(negedge clk_in);
    endtask

    // New packet with random context, both sources ready in the RF
    task automatic drive_instr(input xlen_t instr);
        fetch.instr     = instr;
        fetch.addr      = {30'(rand_bits(30)), 2'b00};
        fetch.age       = rand_bits(32);
        fetch.pred_jump = 1'(rand_bits(1));
        fetch.jump_addr = {30'(rand_bits(30)), 2'b00};
        fetch_valid     = 1'b1;
        rob_next_id     = 4'(rand_bits(4));
        rf_src1.dep     = NO_DEP;
        rf_src1.value   = rand_bits(32);
        rf_src2.dep     = NO_DEP;
        rf_src2.value   = rand_bits(32);
        rob_src1        = '0;
        rob_src2        = '0;
    endtask

    task automatic check_idle();
        check_eq("stall", 32'(stall), 32'd0);
        check_eq("ready", 32'(ready), 32'd0);
    endtask

    task automatic check_dispatched(input unit_ready_t exp_ready);
        check_eq("stall", 32'(stall), 32'd0);
        check_eq("ready", 32'(ready), 32'(exp_ready));
        check_eq("entry.rob_id", 32'(entry.rob_id), 32'(rob_next_id));
        check_eq("entry.instr_addr", entry.instr_addr, fetch.addr);
        check_eq("entry.jump_addr", entry.jump_addr, fetch.jump_addr);
        check_eq("entry.age", entry.age, fetch.age);
    endtask

    task automatic idle_after_reset();
        int i;
        for (i = 0; i < 3; i++) begin
            fetch.instr = enc_r(7'b0, 5'd1, 5'd2, 3'b000, 5'd3);
            fetch_valid = 1'b0;
            step();
            check_idle();
        end
    endtask

    task automatic alu_dispatch();
        int          i;
        logic        is_reg;
        logic        shift;
        logic        alt;
        logic [2:0]  f3;
        logic [11:0] imm;
        reg_idx_t    rd;
        reg_idx_t    ra;
        reg_idx_t    rb;
        xlen_t       instr;
        xlen_t       exp_v2;
        for (i = 0; i < 16; i++) begin
            is_reg = 1'(rand_bits(1));
            f3     = 3'(rand_bits(3));
            rd     = 5'(rand_bits(5));
            ra     = 5'(rand_bits(5));
            rb     = 5'(rand_bits(5));
            imm    = 12'(rand_bits(12));
            shift  = !is_reg && (f3 == 3'b001 || f3 == 3'b101);
            alt    = 1'(rand_bits(1)) && (f3 == 3'b101 || (is_reg && f3 == 3'b000));
            if (is_reg) begin
                instr = enc_r({1'b0, alt, 5'b0}, rb, ra, f3, rd);  // SUB / SRA
            end else begin
                if (shift) begin
                    imm = {1'b0, alt, 5'b0, imm[4:0]};  // SRAI flag plus shamt
                end
                instr = enc_i(OP_IMM, imm, ra, f3, rd);
            end
            drive_instr(instr);
            if (is_reg) begin
                exp_v2 = rf_src2.value;
            end else if (shift) begin
                exp_v2 = {27'b0, imm[4:0]};
            end else begin
                exp_v2 = sext12(imm);
            end
            step();
            check_dispatched(units_for(instr[6:2]));
            check_eq("rs1", 32'(rs1), 32'(ra));
            if (is_reg) begin
                check_eq("rs2", 32'(rs2), 32'(rb));
            end
            check_eq("entry.dest", 32'(entry.dest), 32'(rd));
            check_eq("entry.calc_op", 32'(entry.calc_op), 32'({1'b0, f3}));
            check_eq("entry.calc_alt", 32'(entry.calc_alt), 32'(alt));
            check_eq("entry.dep2", 32'(entry.dep2), 32'(NO_DEP));
            check_eq("entry.value2", entry.value2, exp_v2);
        end
    endtask

    task automatic memory_dispatch();
        int          i;
        logic [2:0]  f3;
        logic [11:0] imm;
        reg_idx_t    rd;
        for (i = 0; i < 5; i++) begin
            f3  = (i < 3) ? 3'(i) : 3'(i + 1);  // LB LH LW LBU LHU
            imm = 12'(rand_bits(12));
            rd  = 5'(rand_bits(5));
            drive_instr(enc_i(OP_LOAD, imm, 5'(rand_bits(5)), f3, rd));
            step();
            check_dispatched(units_for(OP_LOAD));
            check_eq("entry.dest", 32'(entry.dest), 32'(rd));
            check_eq("entry.mem_type", 32'(entry.mem_type), 32'({1'b0, f3}));
            check_eq("entry.imm", entry.imm, sext12(imm));
            check_eq("entry.dep2", 32'(entry.dep2), 32'(NO_DEP));
            check_eq("entry.value2", entry.value2, sext12(imm));
        end
        for (i = 0; i < 6; i++) begin
            f3  = 3'(i % 3);
            imm = 12'(rand_bits(12));
            drive_instr(enc_s(imm, 5'(rand_bits(5)), 5'(rand_bits(5)), f3));
            step();
            check_dispatched(units_for(OP_STORE));
            check_eq("entry.rob_type", 32'(entry.rob_type), 32'(store_rob_type(f3)));
            check_eq("entry.mem_type", 32'(entry.mem_type), 32'({1'b1, f3}));
            check_eq("entry.imm", entry.imm, sext12(imm));
            check_eq("entry.value1", entry.value1, rf_src1.value);
            check_eq("entry.dep2", 32'(entry.dep2), 32'(NO_DEP));
            check_eq("entry.value2", entry.value2, rf_src2.value);
        end
    endtask

    task automatic control_dispatch();
        int          i;
        logic [19:0] uimm;
        logic [20:0] jimm;
        logic [12:0] bimm;
        logic [11:0] imm;
        uimm = 20'(rand_bits(20));
        drive_instr(enc_u(OP_LUI, uimm, 5'(rand_bits(5))));
        step();
        check_dispatched(units_for(OP_LUI));
        check_eq("entry.rob_state", 32'(entry.rob_state), 32'(WRITE_RESULT));
        check_eq("entry.result_value", entry.result_value, {uimm, 12'b0});
        check_eq("entry.is_jump", 32'(entry.is_jump), 32'd0);

        uimm = 20'(rand_bits(20));
        drive_instr(enc_u(OP_AUIPC, uimm, 5'(rand_bits(5))));
        step();
        check_dispatched(units_for(OP_AUIPC));
        check_eq("entry.rob_state", 32'(entry.rob_state), 32'(WRITE_RESULT));
        check_eq("entry.result_value", entry.result_value, fetch.addr + {uimm, 12'b0});

        jimm = {20'(rand_bits(20)), 1'b0};
        drive_instr(enc_j(jimm, 5'(rand_bits(5))));
        step();
        check_dispatched(units_for(OP_JAL));
        check_eq("entry.rob_state", 32'(entry.rob_state), 32'(WRITE_RESULT));
        check_eq("entry.result_value", entry.result_value, fetch.addr + 32'd4);  // Link
        check_eq("entry.is_jump", 32'(entry.is_jump), 32'd1);
        check_eq("entry.imm", entry.imm, {{11{jimm[20]}}, jimm});

        imm = 12'(rand_bits(12));
        drive_instr(enc_i(OP_JALR, imm, 5'(rand_bits(5)), 3'b000, 5'(rand_bits(5))));
        step();
        check_dispatched(units_for(OP_JALR));
        check_eq("entry.rob_type", 32'(entry.rob_type), 32'(JALR));
        check_eq("entry.rob_state", 32'(entry.rob_state), 32'(EXECUTE));
        check_eq("entry.calc_op", 32'(entry.calc_op), 32'(CALC_ADD_SUB));
        check_eq("entry.calc_alt", 32'(entry.calc_alt), 32'd0);
        check_eq("entry.is_jump", 32'(entry.is_jump), 32'd1);
        check_eq("entry.value2", entry.value2, sext12(imm));

        for (i = 0; i < 8; i++) begin
            if (i != 2 && i != 3) begin  // No branch with funct3 2 or 3
                bimm = {12'(rand_bits(12)), 1'b0};
                drive_instr(enc_b(bimm, 5'(rand_bits(5)), 5'(rand_bits(5)), 3'(i)));
                step();
                check_dispatched(units_for(OP_BRANCH));
                check_eq("entry.rob_type", 32'(entry.rob_type), 32'(BRANCH));
                check_eq("entry.calc_op", 32'(entry.calc_op), 32'(branch_op(3'(i))));
                check_eq("entry.is_jump", 32'(entry.is_jump), 32'(fetch.pred_jump));
                check_eq("entry.imm", entry.imm, {{19{bimm[12]}}, bimm});
                check_eq("entry.value2", entry.value2, rf_src2.value);
            end
        end
    endtask

    // Mode 0 RF ready, 1 ROB hit, 2 still pending
    task automatic set_source(input int mode, output operand_t rf, output rob_hit_t rob,
                              output operand_t exp);
        rob_id_t tag;
        tag       = 4'(rand_bits(3));
        rf.value  = rand_bits(32);
        rob.value = rand_bits(32);
        rob.found = (mode != 2);  // Stale hit in mode 0 must lose to the RF
        rf.dep    = (mode == 0) ? NO_DEP : tag;
        if (mode == 0) begin
            exp.dep   = NO_DEP;
            exp.value = rf.value;
        end else if (mode == 1) begin
            exp.dep   = NO_DEP;
            exp.value = rob.value;
        end else begin
            exp.dep   = tag;
            exp.value = '0;
        end
    endtask

    task automatic operand_bypass();
        int       k;
        operand_t exp1;
        operand_t exp2;
        for (k = 0; k < 3; k++) begin
            drive_instr(enc_r(7'b0, 5'(rand_bits(5)), 5'(rand_bits(5)), 3'b000,
                              5'(rand_bits(5))));
            set_source(k, rf_src1, rob_src1, exp1);
            set_source((k + 1) % 3, rf_src2, rob_src2, exp2);
            step();
            check_dispatched(units_for(OP_REG));
            check_eq("entry.dep1", 32'(entry.dep1), 32'(exp1.dep));
            check_eq("entry.value1", entry.value1, exp1.value);
            check_eq("entry.dep2", 32'(entry.dep2), 32'(exp2.dep));
            check_eq("entry.value2", entry.value2, exp2.value);
        end
    endtask

    // Fetch side holds the packet while stalled
    task automatic stall_then_release(input xlen_t instr, input unit_full_t blocking);
        drive_instr(instr);
        full = blocking;
        step();
        check_eq("stall", 32'(stall), 32'd1);
        check_eq("ready", 32'(ready), 32'd0);
        step();
        check_eq("stall", 32'(stall), 32'd1);
        check_eq("ready", 32'(ready), 32'd0);
        full = '0;
        step();
        check_dispatched(units_for(instr[6:2]));
    endtask

    task automatic backpressure_and_flush();
        // Full flags as {rob, rs, lb, sb}
        stall_then_release(enc_r(7'b0, 5'd4, 5'd5, 3'b111, 5'd6), 4'b0100);
        stall_then_release(enc_i(OP_LOAD, 12'h7f0, 5'd7, 3'b010, 5'd8), 4'b0010);
        stall_then_release(enc_s(12'h804, 5'd9, 5'd10, 3'b001), 4'b0001);
        stall_then_release(enc_u(OP_LUI, 20'hbeef1, 5'd11), 4'b1000);

        drive_instr(enc_i(OP_LOAD, 12'h010, 5'd1, 3'b000, 5'd2));
        full = 4'b0101;
        step();
        check_dispatched(units_for(OP_LOAD));
        drive_instr(enc_s(12'h020, 5'd3, 5'd4, 3'b010));
        full = 4'b0110;
        step();
        check_dispatched(units_for(OP_STORE));
        drive_instr(enc_u(OP_AUIPC, 20'h12345, 5'd5));
        full = 4'b0111;
        step();
        check_dispatched(units_for(OP_AUIPC));
        full = '0;

        drive_instr(enc_r(7'b0, 5'd1, 5'd2, 3'b000, 5'd3));
        flush = 1'b1;
        step();
        check_idle();
        flush = 1'b0;
        drive_instr({25'(rand_bits(25)), 7'b1111111});  // Unknown major opcode
        step();
        check_idle();
        fetch_valid = 1'b0;
    endtask

    initial begin
        clk_in      = 1'b0;
        rst_in      = 1'b1;
        fetch_valid = 1'b0;
        flush       = 1'b0;
        fetch       = '0;
        rf_src1     = '0;
        rf_src2     = '0;
        rob_src1    = '0;
        rob_src2    = '0;
        rob_next_id = '0;
        full        = '0;
        repeat (5) @(posedge clk_in);
        @(negedge clk_in);
        check_idle();
        rst_in = 1'b0;

        idle_after_reset();
        alu_dispatch();
        memory_dispatch();
        control_dispatch();
        operand_bypass();
        backpressure_and_flush();

        $display("all tests passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("** Error: watchdog expired before the directed tests finished");
        $display("tests failed");
        $fatal(1, "simulation timeout");
    end

endmodule
